// File: hdl/aguPkg.sv
`default_nettype none

package aguPkg;

    typedef logic [31:0] addrT;
    typedef logic [19:0] vpnT;
    typedef logic [19:0] ppnT;
    typedef logic [5:0]  tagT;
    typedef logic [3:0]  maskT;

    typedef enum logic [2:0] {
        opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw
    } opT;

    typedef enum logic [2:0] {
        excNone, excMisalign, excPageFault, excAccessFault, excReplay
    } excT;

    typedef struct packed {
        logic        valid;
        opT          op;
        addrT        base;
        logic [11:0] imm;
        tagT         tag;
    } aguInT;

    typedef struct packed {
        logic       valid;
        tagT        tag;
        addrT       vaddr;
        addrT       paddr;
        logic [1:0] size;
        logic       signExt;
        logic       isStore;
        maskT       wmask;
        excT        exc;
    } memOpT;

    // sum lets supervisor code touch user pages
    typedef struct packed {
        logic translateEn;
        logic userMode;
        logic sum;
    } vmemT;

    typedef struct packed {
        logic       hit;
        ppnT        ppn;
        logic [2:0] rwx;
        logic       user;
    } tlbResT;

    typedef struct packed {
        logic valid;
        vpnT  vpn;
    } pwReqT;

    typedef struct packed {
        logic       valid;
        ppnT        ppn;
        logic [2:0] rwx;
        logic       user;
        logic       fault;
    } pwRespT;

endpackage

`default_nettype wire

// File: hdl/addrCalc.sv
`default_nettype none

module addrCalc
    import aguPkg::*;
(
    input  aguInT in,
    output memOpT op
);

    addrT vaddr;
    maskT lanes;
    logic misalign;

    assign vaddr = in.base + {{20{in.imm[11]}}, in.imm};

    always_comb begin
        op = '0;
        op.valid = in.valid;
        op.tag = in.tag;
        op.vaddr = vaddr;
        // physical address replaced later when translating
        op.paddr = vaddr;
        op.isStore = in.op inside {opSb, opSh, opSw};

        case (in.op)
            opLb: begin
                op.size = 2'd0;
                op.signExt = 1'b1;
            end
            opLh: begin
                op.size = 2'd1;
                op.signExt = 1'b1;
            end
            opLbu, opSb: op.size = 2'd0;
            opLhu, opSh: op.size = 2'd1;
            default: op.size = 2'd2;
        endcase

        misalign = 1'b0;
        case (op.size)
            2'd0: lanes = 4'b0001 << vaddr[1:0];
            2'd1: begin
                lanes = vaddr[1] ? 4'b1100 : 4'b0011;
                misalign = vaddr[0];
            end
            default: begin
                lanes = 4'b1111;
                misalign = vaddr[1:0] != 2'b00;
            end
        endcase

        // loads write nothing
        op.wmask = op.isStore ? lanes : 4'b0000;
        op.exc = misalign ? excMisalign : excNone;
    end

endmodule

`default_nettype wire

// File: hdl/tlb.sv
`default_nettype none

module tlb
    import aguPkg::*;
#(
    parameter int TlbEntries = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  vpnT    vpn,
    output tlbResT res,
    input  logic   fill,
    input  vpnT    fillVpn,
    input  pwRespT fillResp
);

    localparam int IdxW = (TlbEntries > 1) ? $clog2(TlbEntries) : 1;

    typedef struct packed {
        logic       valid;
        vpnT        vpn;
        ppnT        ppn;
        logic [2:0] rwx;
        logic       user;
    } entryT;

    entryT entries [TlbEntries];
    logic [IdxW-1:0] rrPtr;
    logic [IdxW-1:0] fillIdx;
    logic sameVpn;

    always_comb begin
        res = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (entries[i].valid && entries[i].vpn == vpn) begin
                res.hit = 1'b1;
                res.ppn = entries[i].ppn;
                res.rwx = entries[i].rwx;
                res.user = entries[i].user;
            end
        end
    end

    // refill an entry that already maps this page, else take the round-robin slot
    always_comb begin
        fillIdx = rrPtr;
        sameVpn = 1'b0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (entries[i].valid && entries[i].vpn == fillVpn) begin
                fillIdx = IdxW'(i);
                sameVpn = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TlbEntries; i++) begin
                entries[i].valid <= 1'b0;
            end
            rrPtr <= '0;
        end else if (fill) begin
            entries[fillIdx] <= '{1'b1, fillVpn, fillResp.ppn, fillResp.rwx, fillResp.user};
            if (!sameVpn) begin
                rrPtr <= (rrPtr == IdxW'(TlbEntries - 1)) ? '0 : rrPtr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/walkTimer.sv
`default_nettype none

module walkTimer #(
    parameter int WalkTimeout = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic stop,
    output logic timeout
);

    localparam int CountW = $clog2(WalkTimeout + 1);

    logic [CountW-1:0] count;
    logic running;

    assign timeout = running && count == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count <= '0;
        end else if (start) begin
            running <= 1'b1;
            count <= CountW'(WalkTimeout);
        end else if (stop || timeout) begin
            running <= 1'b0;
            count <= '0;
        end else if (running) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pageWalkCtrl.sv
`default_nettype none

module pageWalkCtrl
    import aguPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   miss,
    input  memOpT  missOp,
    output pwReqT  pwReq,
    input  pwRespT pwResp,
    input  logic   timeout,
    output logic   timerStart,
    output logic   timerStop,
    output logic   fill,
    output vpnT    fillVpn,
    output memOpT  replay,
    output logic   walkBusy
);

    typedef enum logic [1:0] {walkIdle, walkWait, walkReplay} walkStateT;

    walkStateT state;
    memOpT parked;
    logic reqValid;
    vpnT reqVpn;

    assign pwReq = '{valid: reqValid, vpn: reqVpn};
    assign walkBusy = state != walkIdle;
    assign timerStart = miss && state == walkIdle;
    assign timerStop = state == walkWait && pwResp.valid;
    assign fill = state == walkWait && pwResp.valid && !pwResp.fault;
    assign fillVpn = parked.vaddr[31:12];

    // faulted or timed out walks hand the op back right away
    always_comb begin
        replay = parked;
        replay.valid = 1'b0;
        if (state == walkReplay) begin
            replay.valid = 1'b1;
        end else if (state == walkWait && pwResp.valid && pwResp.fault) begin
            replay.valid = 1'b1;
            replay.exc = excPageFault;
        end else if (state == walkWait && !pwResp.valid && timeout) begin
            replay.valid = 1'b1;
            replay.exc = excAccessFault;
        end
    end

    always_ff @(posedge clk) begin
        if (timerStart) begin
            parked <= missOp;
            reqVpn <= missOp.vaddr[31:12];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= walkIdle;
            reqValid <= 1'b0;
        end else begin
            reqValid <= 1'b0;
            case (state)
                walkIdle: begin
                    if (miss) begin
                        state <= walkWait;
                        reqValid <= 1'b1;
                    end
                end
                walkWait: begin
                    if (pwResp.valid) begin
                        state <= pwResp.fault ? walkIdle : walkReplay;
                    end else if (timeout) begin
                        state <= walkIdle;
                    end
                end
                default: state <= walkIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/aguIssue.sv
`default_nettype none

module aguIssue
    import aguPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  memOpT  calcOp,
    input  memOpT  replay,
    input  logic   walkBusy,
    input  vmemT   vmem,
    output vpnT    lookupVpn,
    input  tlbResT tlbRes,
    output logic   miss,
    output memOpT  missOp,
    output memOpT  out
);

    memOpT cur;
    memOpT result;
    memOpT bounce;
    logic bounceNew;
    logic permFault;

    // replay first, then a bounced op, then the new one
    always_comb begin
        bounceNew = 1'b0;
        if (replay.valid) begin
            cur = replay;
            bounceNew = calcOp.valid;
        end else if (bounce.valid) begin
            cur = bounce;
            bounceNew = calcOp.valid;
        end else begin
            cur = calcOp;
        end
    end

    assign lookupVpn = cur.vaddr[31:12];
    assign missOp = cur;

    always_comb begin
        permFault = (cur.isStore ? !tlbRes.rwx[1] : !tlbRes.rwx[2])
            || (vmem.userMode && !tlbRes.user)
            || (!vmem.userMode && tlbRes.user && !vmem.sum);
    end

    always_comb begin
        result = cur;
        miss = 1'b0;
        // a preset exception passes through untouched
        if (cur.valid && cur.exc == excNone && vmem.translateEn) begin
            if (tlbRes.hit) begin
                result.paddr = {tlbRes.ppn, cur.vaddr[11:0]};
                if (permFault) begin
                    result.exc = excPageFault;
                end
            end else if (walkBusy) begin
                result.exc = excReplay;
            end else begin
                // parked in the walk controller, reported later
                miss = 1'b1;
                result.valid = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        out <= result;
        if (rst) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bounceNew) begin
            bounce <= calcOp;
            bounce.exc <= excReplay;
        end else if (!replay.valid) begin
            bounce.valid <= 1'b0;
        end
        if (rst) begin
            bounce.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/agu.sv
`default_nettype none

module agu
    import aguPkg::*;
#(
    parameter int TlbEntries = 4,
    parameter int WalkTimeout = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  aguInT  in,
    input  vmemT   vmem,
    output memOpT  out,
    output pwReqT  pwReq,
    input  pwRespT pwResp
);

    memOpT calcOp;
    memOpT replay;
    memOpT missOp;
    vpnT lookupVpn;
    vpnT fillVpn;
    tlbResT tlbRes;
    logic miss;
    logic walkBusy;
    logic fill;
    logic timerStart;
    logic timerStop;
    logic timeout;

    addrCalc calc (
        .in(in),
        .op(calcOp)
    );

    tlb #(.TlbEntries(TlbEntries)) dtlb (
        .clk(clk),
        .rst(rst),
        .vpn(lookupVpn),
        .res(tlbRes),
        .fill(fill),
        .fillVpn(fillVpn),
        .fillResp(pwResp)
    );

    aguIssue issue (
        .clk(clk),
        .rst(rst),
        .calcOp(calcOp),
        .replay(replay),
        .walkBusy(walkBusy),
        .vmem(vmem),
        .lookupVpn(lookupVpn),
        .tlbRes(tlbRes),
        .miss(miss),
        .missOp(missOp),
        .out(out)
    );

    pageWalkCtrl walkCtrl (
        .clk(clk),
        .rst(rst),
        .miss(miss),
        .missOp(missOp),
        .pwReq(pwReq),
        .pwResp(pwResp),
        .timeout(timeout),
        .timerStart(timerStart),
        .timerStop(timerStop),
        .fill(fill),
        .fillVpn(fillVpn),
        .replay(replay),
        .walkBusy(walkBusy)
    );

    walkTimer #(.WalkTimeout(WalkTimeout)) timer (
        .clk(clk),
        .rst(rst),
        .start(timerStart),
        .stop(timerStop),
        .timeout(timeout)
    );

endmodule

`default_nettype wire

// File: bench/aguTb.sv
`default_nettype none

module aguTb
    import aguPkg::*;
();

    typedef struct packed {
        opT          op;
        addrT        base;
        logic [11:0] imm;
        vmemT        vmem;
        logic        silent;
        logic        probe;
        logic        expWalk;
        excT         exc;
        addrT        paddr;
        maskT        wmask;
        logic        signExt;
        logic [1:0]  size;
        logic        isStore;
    } testT;

    // flag bits for a silent walker, a probe op during the walk and one expected walk
    localparam logic [2:0] Silent = 3'b100;
    localparam logic [2:0] Probe = 3'b010;
    localparam logic [2:0] Walk = 3'b001;
    localparam vmemT VOff = 3'b000;
    localparam vmemT VSup = 3'b100;
    localparam vmemT VUser = 3'b110;
    localparam vmemT VSum = 3'b101;
    localparam tagT ProbeTag = 6'h3f;

    logic clk;
    logic rst;
    aguInT in;
    vmemT vmem;
    memOpT out;
    pwReqT pwReq;
    pwRespT pwResp;

    testT tests[$];
    string names[$];
    int errors;
    int walks;
    vpnT walkVpn;
    logic silent;

    agu #(.TlbEntries(2), .WalkTimeout(16)) uut (
        .clk(clk),
        .rst(rst),
        .in(in),
        .vmem(vmem),
        .out(out),
        .pwReq(pwReq),
        .pwResp(pwResp)
    );

    // page table rule of the walker model
    function automatic pwRespT walkerReply(vpnT vpn);
        pwRespT r;
        r.valid = 1'b1;
        r.ppn = vpn ^ 20'h5a5a5;
        r.rwx = vpn[2:0];
        r.user = vpn[3];
        r.fault = vpn[4];
        return r;
    endfunction

    function automatic testT withExpected(testT t);
        addrT va;
        pwRespT walk;
        logic store;
        int size;
        va = t.base + {{20{t.imm[11]}}, t.imm};
        walk = walkerReply(va[31:12]);
        store = t.op inside {opSb, opSh, opSw};
        size = (t.op inside {opLw, opSw}) ? 4 : ((t.op inside {opLh, opLhu, opSh}) ? 2 : 1);
        t.signExt = t.op inside {opLb, opLh};
        t.isStore = store;
        t.size = 2'($clog2(size));
        t.wmask = 4'b0000;
        if (store) begin
            case (size)
                1: t.wmask = 4'b0001 << va[1:0];
                2: t.wmask = va[1] ? 4'b1100 : 4'b0011;
                default: t.wmask = 4'b1111;
            endcase
        end
        t.paddr = va;
        t.exc = excNone;
        if ((size == 2 && va[0]) || (size == 4 && va[1:0] != 2'b00)) begin
            t.exc = excMisalign;
        end else if (t.vmem.translateEn) begin
            t.paddr = {walk.ppn, va[11:0]};
            if (t.silent) begin
                t.exc = excAccessFault;
            end else if (walk.fault
                    || (store ? !walk.rwx[1] : !walk.rwx[2])
                    || (t.vmem.userMode && !walk.user)
                    || (!t.vmem.userMode && walk.user && !t.vmem.sum)) begin
                t.exc = excPageFault;
            end
        end
        return t;
    endfunction

    function automatic void addTest(string name, opT op, addrT base, logic [11:0] imm,
            vmemT vm, logic [2:0] flags);
        testT t;
        t = '0;
        t.op = op;
        t.base = base;
        t.imm = imm;
        t.vmem = vm;
        {t.silent, t.probe, t.expWalk} = flags;
        tests.push_back(withExpected(t));
        names.push_back(name);
    endfunction

    task automatic buildTable();
        addTest("lb off", opLb, 32'h0000_1003, 12'h000, VOff, 3'b000);
        addTest("lh off", opLh, 32'h0000_2000, 12'hffe, VOff, 3'b000);
        addTest("lw off", opLw, 32'h0000_3010, 12'h7fc, VOff, 3'b000);
        addTest("lbu off", opLbu, 32'h8000_0000, 12'h801, VOff, 3'b000);
        addTest("lhu off", opLhu, 32'h0000_0102, 12'h000, VOff, 3'b000);
        addTest("sb off", opSb, 32'h0000_4001, 12'h001, VOff, 3'b000);
        addTest("sh off", opSh, 32'h0000_5000, 12'h002, VOff, 3'b000);
        addTest("sw off", opSw, 32'h0000_6004, 12'hffc, VOff, 3'b000);
        addTest("lh misaligned", opLh, 32'h0000_1001, 12'h000, VOff, 3'b000);
        addTest("sw misaligned", opSw, 32'h0000_1002, 12'h000, VOff, 3'b000);
        addTest("first touch", opLw, 32'h0000_6000, 12'h010, VSup, Walk);
        addTest("same page", opSb, 32'h0000_6000, 12'h123, VSup, 3'b000);
        addTest("user on super page", opLw, 32'h0000_6000, 12'h020, VUser, 3'b000);
        addTest("store read-only", opSw, 32'h0000_4000, 12'h008, VSup, Walk);
        addTest("user page", opLw, 32'h0000_e000, 12'h004, VUser, Walk);
        addTest("super no sum", opLw, 32'h0000_e000, 12'h008, VSup, 3'b000);
        addTest("super with sum", opLw, 32'h0000_e000, 12'h008, VSum, 3'b000);
        addTest("walk fault", opLw, 32'h0001_6000, 12'h000, VSup, Walk);
        addTest("walk fault again", opLw, 32'h0001_6000, 12'h000, VSup, Walk);
        addTest("silent walker", opLw, 32'h0002_6000, 12'h000, VSup, Silent | Probe | Walk);
        addTest("evict p1", opLw, 32'h0010_6000, 12'h000, VSup, Walk);
        addTest("evict p2", opLw, 32'h0020_6000, 12'h000, VSup, Walk);
        addTest("evict p3", opLw, 32'h0030_6000, 12'h000, VSup, Walk);
        addTest("p1 again", opLw, 32'h0010_6000, 12'h000, VSup, Walk);
    endtask

    task automatic mismatch(string name, string field, logic [31:0] expected,
            logic [31:0] actual);
        errors++;
        $display("FAIL %s %s expected %h actual %h", name, field, expected, actual);
    endtask

    task automatic issueOp(opT op, addrT base, logic [11:0] imm, vmemT vm, tagT tag);
        in.valid = 1'b1;
        in.op = op;
        in.base = base;
        in.imm = imm;
        in.tag = tag;
        vmem = vm;
        @(negedge clk);
        in.valid = 1'b0;
    endtask

    task automatic waitOut(string name, tagT tag, output logic seen);
        int cycles;
        cycles = 0;
        while (!(out.valid && out.tag == tag) && cycles < 80) begin
            @(negedge clk);
            cycles++;
        end
        seen = out.valid && out.tag == tag;
        assert (seen) else begin
            errors++;
            $display("test %s: no result came out within 80 cycles", name);
        end
    endtask

    task automatic checkOp(string name, testT t, int walksSeen);
        addrT va;
        va = t.base + {{20{t.imm[11]}}, t.imm};
        assert (out.exc == t.exc) else mismatch(name, "exc", 32'(t.exc), 32'(out.exc));
        assert (out.wmask == t.wmask) else mismatch(name, "wmask", 32'(t.wmask), 32'(out.wmask));
        assert (out.signExt == t.signExt)
            else mismatch(name, "signExt", 32'(t.signExt), 32'(out.signExt));
        assert (out.size == t.size) else mismatch(name, "size", 32'(t.size), 32'(out.size));
        assert (out.isStore == t.isStore)
            else mismatch(name, "isStore", 32'(t.isStore), 32'(out.isStore));
        assert (out.vaddr == va) else mismatch(name, "vaddr", va, out.vaddr);
        // paddr only means something for a clean access
        assert (t.exc != excNone || out.paddr == t.paddr)
            else mismatch(name, "paddr", t.paddr, out.paddr);
        assert (walksSeen == int'(t.expWalk))
            else mismatch(name, "walks", 32'(t.expWalk), 32'(walksSeen));
        assert (!t.expWalk || walkVpn == va[31:12])
            else mismatch(name, "walk vpn", 32'(va[31:12]), 32'(walkVpn));
    endtask

    task automatic runTest(int idx);
        testT t;
        int walksBefore;
        logic seen;
        t = tests[idx];
        silent = t.silent;
        walksBefore = walks;
        issueOp(t.op, t.base, t.imm, t.vmem, tagT'(idx));
        if (t.probe) begin
            // another miss while the first walk is still pending
            @(negedge clk);
            issueOp(opLw, 32'h0004_6000, 12'h000, t.vmem, ProbeTag);
            waitOut(names[idx], ProbeTag, seen);
            if (seen) begin
                assert (out.exc == excReplay)
                    else mismatch(names[idx], "probe exc", 32'(excReplay), 32'(out.exc));
            end
        end
        waitOut(names[idx], tagT'(idx), seen);
        if (seen) begin
            checkOp(names[idx], t, walks - walksBefore);
        end
    endtask

    initial begin : clockGen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : walker
        int delay;
        vpnT vpn;
        pwResp = '0;
        walks = 0;
        walkVpn = '0;
        void'($urandom(32'h3a0de967));
        forever begin
            @(negedge clk);
            if (pwReq.valid) begin
                walks++;
                walkVpn = pwReq.vpn;
                vpn = pwReq.vpn;
                delay = $urandom_range(10, 1);
                repeat (delay) @(negedge clk);
                if (!silent) begin
                    pwResp = walkerReply(vpn);
                    @(negedge clk);
                    pwResp = '0;
                end
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (tests.size() * 40 + 8) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        in = '0;
        vmem = '0;
        rst = 1'b1;
        silent = 1'b0;
        errors = 0;
        buildTable();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        foreach (tests[i]) begin
            runTest(i);
        end
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/aguPkg.sv
hdl/addrCalc.sv
hdl/tlb.sv
hdl/walkTimer.sv
hdl/pageWalkCtrl.sv
hdl/aguIssue.sv
hdl/agu.sv
bench/aguTb.sv

// File: Makefile
TOP := aguTb
BUILD := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf $(BUILD) sim.log
